//--- periph_pkg.sv
`default_nettype none

package periph_pkg;

        // ------------------------------------------------------------
        // Widths with a meaning
        // ------------------------------------------------------------
        typedef logic [31:0] addr_t;            // APB address
        typedef logic [31:0] data_t;            // APB data word
        typedef logic [3:0]  slot_t;            // paddr[15:12]
        typedef logic [3:0]  reg_off_t;         // paddr[3:0]

        localparam int SAMPLE_W_DEF = 12;       // Converter width, 8 to 16 works

        // APB request, port to every slave
        typedef struct packed {
                logic  psel;
                logic  penable;
                logic  pwrite;
                addr_t paddr;
                data_t pwdata;
        } apb_req_t;

        // APB response, slave to mux to port
        typedef struct packed {
                data_t prdata;
                logic  pready;                  // Always high, no wait states
                logic  pslverr;
        } apb_rsp_t;

        // Sequencer to external converter
        typedef struct packed {
                logic start;                    // One-cycle conversion kick
                logic oe;                       // One-cycle output enable
        } adc_cmd_t;

        // ------------------------------------------------------------
        // Address map
        // ------------------------------------------------------------
        localparam slot_t SLOT_ADC = 4'd0;
        localparam slot_t SLOT_TMU = 4'd1;

        localparam reg_off_t OFF_CTRL   = 4'h0;   // ADC
        localparam reg_off_t OFF_STATUS = 4'h4;
        localparam reg_off_t OFF_DATA   = 4'h8;

        localparam reg_off_t OFF_OFFSET = 4'h0;   // TMU
        localparam reg_off_t OFF_RESULT = 4'h4;
        localparam reg_off_t OFF_COUNT  = 4'h8;

        // Conversion sequencer
        typedef enum logic [1:0] {
                IDLE,
                START,
                WAIT_EOC,
                READ
        } adc_state_t;

endpackage

`default_nettype wire

//--- apb_slave_mux.sv
`default_nettype none

module apb_slave_mux (
        input  wire periph_pkg::apb_req_t req,
        output periph_pkg::apb_req_t      req_adc,
        output periph_pkg::apb_req_t      req_tmu,
        input  wire periph_pkg::apb_rsp_t rsp_adc,
        input  wire periph_pkg::apb_rsp_t rsp_tmu,
        output periph_pkg::apb_rsp_t      rsp
);
        import periph_pkg::*;

        slot_t slot;
        logic  hit_adc;
        logic  hit_tmu;

        assign slot    = req.paddr[15:12];
        assign hit_adc = (slot == SLOT_ADC);
        assign hit_tmu = (slot == SLOT_TMU);

        // Request fan-out, only psel is qualified per slot
        always_comb begin
                req_adc      = req;
                req_adc.psel = req.psel & hit_adc;
                req_tmu      = req;
                req_tmu.psel = req.psel & hit_tmu;
        end

        // ------------------------------------------------------------
        // Read-back select
        // ------------------------------------------------------------
        always_comb begin
                if (hit_adc) begin
                        rsp = rsp_adc;
                end else if (hit_tmu) begin
                        rsp = rsp_tmu;
                end else begin                          // Unpopulated slot
                        rsp.prdata  = '0;               // Reads zero
                        rsp.pready  = 1'b1;
                        rsp.pslverr = req.psel & req.penable;   // Error in access phase
                end
        end

        // A populated slave never reports an error through the mux
        always_comb begin
                if (req.psel && (hit_adc || hit_tmu)) begin
                        a_no_err_populated: assert final (!rsp.pslverr)
                                else $error("pslverr from populated slot %0d", slot);
                end
        end

endmodule

`default_nettype wire

//--- adc_apb_regs.sv
`default_nettype none

module adc_apb_regs #(
        parameter int SAMPLE_W = periph_pkg::SAMPLE_W_DEF
) (
        input  wire                       clk,
        input  wire                       RSTn,
        input  wire periph_pkg::apb_req_t req,
        output periph_pkg::apb_rsp_t      rsp,
        input  wire [SAMPLE_W-1:0]        sample,
        input  wire                       sample_valid,
        output logic                      sample_enable,
        output logic                      fwd_enable
);
        import periph_pkg::*;

        reg_off_t            off;
        logic                acc;               // Access phase on this slot
        logic                wr_ctrl;
        logic                rd_data;           // DATA read clears the flag
        logic [1:0]          ctrl_q;            // [1] fwd, [0] sample
        logic                flag_q;            // Sticky new-sample flag
        logic [SAMPLE_W-1:0] data_q;            // Last sample

        assign off     = req.paddr[3:0];
        assign acc     = req.psel & req.penable;
        assign wr_ctrl = acc & req.pwrite & (off == OFF_CTRL);
        assign rd_data = acc & ~req.pwrite & (off == OFF_DATA);

        // ------------------------------------------------------------
        // Registers
        // ------------------------------------------------------------
        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        ctrl_q <= '0;
                        flag_q <= 1'b0;
                        data_q <= '0;
                end else begin
                        if (wr_ctrl) begin
                                ctrl_q <= req.pwdata[1:0];
                        end
                        if (sample_valid) begin
                                data_q <= sample;
                                flag_q <= 1'b1;         // Set wins over read clear
                        end else if (rd_data) begin
                                flag_q <= 1'b0;
                        end
                end
        end

        assign sample_enable = ctrl_q[0];
        assign fwd_enable    = ctrl_q[1];

        // Read-back from registered state only
        always_comb begin
                rsp.prdata  = '0;
                rsp.pready  = 1'b1;
                rsp.pslverr = 1'b0;
                case (off)
                        OFF_CTRL:   rsp.prdata[1:0]          = ctrl_q;
                        OFF_STATUS: rsp.prdata[0]            = flag_q;
                        OFF_DATA:   rsp.prdata[SAMPLE_W-1:0] = data_q;  // Zero-extended
                        default:    rsp.prdata               = '0;
                endcase
        end

endmodule

`default_nettype wire

//--- adc_sample_ctrl.sv
`default_nettype none

module adc_sample_ctrl #(
        parameter int SAMPLE_W = periph_pkg::SAMPLE_W_DEF
) (
        input  wire                  clk,
        input  wire                  RSTn,
        input  wire                  sample_enable,
        input  wire                  eoc,               // Converter done
        input  wire [SAMPLE_W-1:0]   adc_data,
        output periph_pkg::adc_cmd_t cmd,
        output logic [SAMPLE_W-1:0]  sample,
        output logic                 sample_valid
);
        import periph_pkg::*;

        adc_state_t state_q;
        adc_state_t state_d;
        logic       cap_q;                      // Capture happened last edge

        // ------------------------------------------------------------
        // Next state
        // ------------------------------------------------------------
        always_comb begin
                state_d = state_q;
                case (state_q)
                        IDLE: begin
                                // Hold off until the pending sample_valid has gone out
                                if (sample_enable && !cap_q) begin
                                        state_d = START;
                                end
                        end
                        START: begin
                                state_d = WAIT_EOC;     // Start is one cycle
                        end
                        WAIT_EOC: begin
                                if (eoc) begin
                                        state_d = READ; // oe next cycle
                                end
                        end
                        READ: begin
                                state_d = IDLE;
                        end
                        default: begin
                                state_d = IDLE;
                        end
                endcase
        end

        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        state_q      <= IDLE;
                        cap_q        <= 1'b0;
                        sample_valid <= 1'b0;
                end else begin
                        state_q      <= state_d;
                        cap_q        <= (state_q == READ);
                        sample_valid <= cap_q;          // One cycle after capture
                end
        end

        // Capture at the edge that ends the oe cycle
        always_ff @(posedge clk) begin
                if (state_q == READ) begin
                        sample <= adc_data;
                end
        end

        assign cmd = '{start: (state_q == START), oe: (state_q == READ)};

        // ------------------------------------------------------------
        // Checks on the converter handshake
        // ------------------------------------------------------------
        a_start_oe_excl: assert property (@(posedge clk) disable iff (!RSTn)
                !(cmd.start && cmd.oe));

        a_start_pulse: assert property (@(posedge clk) disable iff (!RSTn)
                cmd.start |=> !cmd.start);

endmodule

`default_nettype wire

//--- tmu_core.sv
`default_nettype none

module tmu_core #(
        parameter int SAMPLE_W = periph_pkg::SAMPLE_W_DEF
) (
        input  wire                 clk,
        input  wire                 RSTn,
        input  wire [SAMPLE_W-1:0]  sample,
        input  wire                 sample_valid,
        input  wire                 fwd_enable,
        input  wire [SAMPLE_W-1:0]  offset,
        output logic [SAMPLE_W-1:0] result,
        output logic                result_valid
);
        logic                take;              // Forwarded sample
        logic [SAMPLE_W-1:0] s1_sample;
        logic                s1_valid;
        logic [SAMPLE_W-1:0] diff;

        assign take = sample_valid & fwd_enable;

        // Sample minus offset with a floor at zero
        assign diff = (s1_sample > offset) ? (s1_sample - offset) : '0;

        // ------------------------------------------------------------
        // Stage control
        // ------------------------------------------------------------
        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        s1_valid     <= 1'b0;
                        result_valid <= 1'b0;
                end else begin
                        s1_valid     <= take;
                        result_valid <= s1_valid;
                end
        end

        // Data stages
        always_ff @(posedge clk) begin
                if (take) begin
                        s1_sample <= sample;            // Stage 1
                end
                if (s1_valid) begin
                        result <= diff;                 // Stage 2 takes the offset here
                end
        end

endmodule

`default_nettype wire

//--- tmu_apb_regs.sv
`default_nettype none

module tmu_apb_regs #(
        parameter int SAMPLE_W = periph_pkg::SAMPLE_W_DEF
) (
        input  wire                       clk,
        input  wire                       RSTn,
        input  wire periph_pkg::apb_req_t req,
        output periph_pkg::apb_rsp_t      rsp,
        input  wire [SAMPLE_W-1:0]        result,
        input  wire                       result_valid,
        output logic [SAMPLE_W-1:0]       offset
);
        import periph_pkg::*;

        reg_off_t            off;
        logic                wr_offset;
        logic [SAMPLE_W-1:0] offset_q;          // Software value
        logic [SAMPLE_W-1:0] result_q;          // Last TMU result
        logic [7:0]          count_q;           // Results seen, wraps

        assign off       = req.paddr[3:0];
        assign wr_offset = req.psel & req.penable & req.pwrite & (off == OFF_OFFSET);

        // ------------------------------------------------------------
        // Registers
        // ------------------------------------------------------------
        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        offset_q <= '0;
                        result_q <= '0;
                        count_q  <= '0;
                end else begin
                        if (wr_offset) begin
                                offset_q <= req.pwdata[SAMPLE_W-1:0];
                        end
                        if (result_valid) begin
                                result_q <= result;
                                count_q  <= count_q + 8'd1;
                        end
                end
        end

        assign offset = offset_q;

        // Read-back
        always_comb begin
                rsp.prdata  = '0;
                rsp.pready  = 1'b1;
                rsp.pslverr = 1'b0;
                case (off)
                        OFF_OFFSET: rsp.prdata[SAMPLE_W-1:0] = offset_q;
                        OFF_RESULT: rsp.prdata[SAMPLE_W-1:0] = result_q;
                        OFF_COUNT:  rsp.prdata[7:0]          = count_q;
                        default:    rsp.prdata               = '0;
                endcase
        end

        // COUNT moves only with a TMU result
        a_count_stable: assert property (@(posedge clk) disable iff (!RSTn)
                !result_valid |=> $stable(count_q));

endmodule

`default_nettype wire

//--- periph_top.sv
`default_nettype none

module periph_top #(
        parameter int SAMPLE_W = periph_pkg::SAMPLE_W_DEF
) (
        input  wire                       clk,
        input  wire                       RSTn,
        input  wire periph_pkg::apb_req_t apb_req,
        output periph_pkg::apb_rsp_t      apb_rsp,
        input  wire                       eoc,
        input  wire [SAMPLE_W-1:0]        adc_data,
        output periph_pkg::adc_cmd_t      adc_cmd
);
        import periph_pkg::*;

        // ------------------------------------------------------------
        // APB slots
        // ------------------------------------------------------------
        apb_req_t            req_adc;           // Slot 0
        apb_req_t            req_tmu;           // Slot 1
        apb_rsp_t            rsp_adc;
        apb_rsp_t            rsp_tmu;

        logic                sample_enable;
        logic                fwd_enable;
        logic [SAMPLE_W-1:0] sample;
        logic                sample_valid;
        logic [SAMPLE_W-1:0] offset;
        logic [SAMPLE_W-1:0] result;
        logic                result_valid;

        apb_slave_mux i_mux (
                .req     (apb_req),
                .req_adc (req_adc),
                .req_tmu (req_tmu),
                .rsp_adc (rsp_adc),
                .rsp_tmu (rsp_tmu),
                .rsp     (apb_rsp)
        );

        adc_apb_regs #(.SAMPLE_W(SAMPLE_W)) i_adc_regs (
                .clk           (clk),
                .RSTn          (RSTn),
                .req           (req_adc),
                .rsp           (rsp_adc),
                .sample        (sample),
                .sample_valid  (sample_valid),
                .sample_enable (sample_enable),
                .fwd_enable    (fwd_enable)
        );

        // Converter sequencing
        adc_sample_ctrl #(.SAMPLE_W(SAMPLE_W)) i_adc_ctrl (
                .clk           (clk),
                .RSTn          (RSTn),
                .sample_enable (sample_enable),
                .eoc           (eoc),
                .adc_data      (adc_data),
                .cmd           (adc_cmd),
                .sample        (sample),
                .sample_valid  (sample_valid)
        );

        // Offset unit
        tmu_core #(.SAMPLE_W(SAMPLE_W)) i_tmu_core (
                .clk          (clk),
                .RSTn         (RSTn),
                .sample       (sample),
                .sample_valid (sample_valid),
                .fwd_enable   (fwd_enable),
                .offset       (offset),
                .result       (result),
                .result_valid (result_valid)
        );

        tmu_apb_regs #(.SAMPLE_W(SAMPLE_W)) i_tmu_regs (
                .clk          (clk),
                .RSTn         (RSTn),
                .req          (req_tmu),
                .rsp          (rsp_tmu),
                .result       (result),
                .result_valid (result_valid),
                .offset       (offset)
        );

endmodule

`default_nettype wire

//--- tb_periph_top.sv
`default_nettype none

module tb_periph_top;
        import periph_pkg::*;

        localparam int SAMPLE_W = 12;
        localparam int WAIT_MAX = 200;          // Cycles or polls per wait

        logic                clk = 1'b0;
        logic                RSTn;
        apb_req_t            apb_req;
        apb_rsp_t            apb_rsp;
        logic                eoc;
        logic [SAMPLE_W-1:0] adc_data;
        adc_cmd_t            adc_cmd;
        int                  checks = 0;
        int                  errors = 0;        // Mismatches
        int                  failures = 0;      // Timeouts and file trouble
        logic [15:0]         lfsr = 16'd16;     // Fibonacci LFSR with seed 16
        logic [SAMPLE_W-1:0] sample_q[$];       // Samples for the converter
        int                  queued = 0;
        int                  delivered = 0;     // Handed over on oe
        int                  conv_delay = 0;
        logic                start_seen = 1'b0;
        logic                timed_out = 1'b0;  // A wait ran out

        periph_top #(.SAMPLE_W(SAMPLE_W)) i_dut (
                .clk      (clk),
                .RSTn     (RSTn),
                .apb_req  (apb_req),
                .apb_rsp  (apb_rsp),
                .eoc      (eoc),
                .adc_data (adc_data),
                .adc_cmd  (adc_cmd)
        );

        always #5 clk = ~clk;                   // Period 10

        // One LFSR step per bit taken
        function automatic int lfsr_bits(input int n);
                int   v;
                logic fb;
                v = 0;
                repeat (n) begin
                        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];  // Taps 16 14 13 11
                        lfsr = {lfsr[14:0], fb};
                        v    = (v << 1) | fb;
                end
                return v;
        endfunction

        task automatic end_run();
                $display("checks %0d, mismatches %0d, other failures %0d",
                         checks, errors, failures);
                if (errors == 0 && failures == 0) begin
                        $display("TB PASSED");
                end else begin
                        $display("TB FAILED");
                end
                $finish;
        endtask

        task automatic give_up(input string what);
                failures++;
                timed_out = 1'b1;
                $display("timeout at %0t while waiting for %s", $time, what);
        endtask

        task automatic check_value(input string name, input data_t got, input data_t exp);
                checks++;
                assert (got == exp) else begin
                        errors++;
                        $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
                end
        endtask

        // ------------------------------------------------------------
        // APB master with setup and access phases
        // ------------------------------------------------------------
        task automatic apb_xfer(input logic wr, input slot_t slot, input reg_off_t off,
                        input data_t wdata, output data_t rdata, output logic err);
                @(posedge clk);
                apb_req <= '{1'b1, 1'b0, wr, {16'h0, slot, 8'h0, off}, wdata};   // Setup
                @(posedge clk);
                apb_req.penable <= 1'b1;                // Access
                @(posedge clk);                         // No wait states, so done here
                rdata = apb_rsp.prdata;                 // Values of the access cycle
                err   = apb_rsp.pslverr;
                check_value("pready", {31'h0, apb_rsp.pready}, 32'h1);
                apb_req <= '0;
        endtask

        // Converter model gives one queued sample per start after a random delay
        always @(posedge clk) begin
                if (adc_cmd.oe) begin
                        eoc       <= 1'b0;
                        delivered <= delivered + 1;
                end
                if (adc_cmd.start) begin
                        start_seen = 1'b1;
                end
                if (conv_delay > 0) begin
                        conv_delay = conv_delay - 1;
                        eoc <= (conv_delay == 0);       // Rises when the delay runs out
                end else if (start_seen && sample_q.size() > 0) begin
                        adc_data   <= sample_q.pop_front();
                        conv_delay = 1 + lfsr_bits(2);  // 1 to 4 cycles
                        start_seen = 1'b0;
                end
        end

        // ------------------------------------------------------------
        // Pattern runner
        // ------------------------------------------------------------
        initial begin
                int          fd;
                int          n;
                string       line;
                logic [7:0]  cmd;
                logic [31:0] a;
                logic [31:0] b;
                logic [31:0] c;
                data_t       rd;
                logic        err;
                logic        exp_err;
                logic [7:0]  last_count;
                RSTn       = 1'b0;
                apb_req    = '0;
                eoc        = 1'b0;
                adc_data   = '0;
                last_count = '0;
                repeat (2) @(posedge clk);
                RSTn <= 1'b1;
                fd = $fopen("tb_periph_patterns.txt", "r");
                if (fd == 0) begin
                        failures++;
                        $display("cannot open the pattern file");
                end
                while (fd != 0 && !timed_out && $fgets(line, fd) > 0) begin
                        if (line.len() < 2 || line[0] == "#") begin
                                continue;               // Blank or column notes
                        end
                        n = $sscanf(line, "%c %h %h %h", cmd, a, b, c);
                        case (cmd)
                        "W", "R", "E": begin
                                // Only slots 0 and 1 are populated
                                exp_err = (cmd == "E") || (cmd == "W" &&
                                          a[3:0] != SLOT_ADC && a[3:0] != SLOT_TMU);
                                apb_xfer(cmd == "W", a[3:0], b[3:0], c, rd, err);
                                check_value("pslverr", err, exp_err);
                                if (cmd != "W") begin
                                        check_value("prdata", rd, (cmd == "R") ? c : '0);
                                end
                        end
                        "S": begin
                                @(negedge clk);         // Clear of the model's edge
                                sample_q.push_back(a[SAMPLE_W-1:0]);
                                queued++;
                                for (n = 0; !timed_out && delivered != queued; n++) begin
                                        if (n == WAIT_MAX) begin
                                                give_up("converter hand-over");
                                        end else begin
                                                @(posedge clk);
                                        end
                                end
                                repeat (3) @(posedge clk);      // Rest of oe to RESULT
                        end
                        "N": begin
                                last_count = a[7:0];
                                n = 0;
                                do begin                // Poll COUNT
                                        if (n == WAIT_MAX) begin
                                                give_up("COUNT");
                                        end else begin
                                                apb_xfer(1'b0, SLOT_TMU, OFF_COUNT, '0, rd, err);
                                                n++;
                                        end
                                end while (!timed_out && rd[7:0] != last_count);
                        end
                        default: begin
                                failures++;
                                $display("unknown pattern command %c", cmd);
                        end
                        endcase
                end
                // A spare sample with forwarding on would show any new start in COUNT
                if (!timed_out) begin
                        apb_xfer(1'b1, SLOT_ADC, OFF_CTRL, 32'h2, rd, err);  // Sampling stays off
                        @(negedge clk);
                        sample_q.push_back('1);         // Taken only if a start comes
                end
                // COUNT frozen over 50 cycles of polling
                for (n = 0; !timed_out && n < 50; n += 3) begin       // 3 cycles per read
                        apb_xfer(1'b0, SLOT_TMU, OFF_COUNT, '0, rd, err);
                        check_value("COUNT", rd, {24'h0, last_count});
                end
                end_run();
        end

endmodule

`default_nettype wire

//--- tb_periph_patterns.txt
# W slot offset value | R slot offset expected | E slot offset | S sample | N count
# All numbers hex; slot 0 ADC, slot 1 TMU, slots 2 and 3 unpopulated
R 0 0 0
R 0 4 0
R 0 8 0
R 1 0 0
R 1 4 0
R 1 8 0
W 0 0 2
R 0 0 2
W 1 0 abc
R 1 0 abc
W 0 0 1
S 2a5
R 0 4 1
R 0 8 2a5
R 0 4 0
R 1 8 0
W 1 0 100
W 0 0 3
S 345
N 1
R 1 4 245
S 0f0
N 2
R 1 4 0
W 1 0 010
S 345
N 3
R 1 4 335
E 2 0
E 3 8
W 2 0 fff
W 3 0 fff
R 1 0 10
R 0 0 3
W 0 0 0
S 555
R 0 8 555
N 3

//--- build.f
periph_pkg.sv
apb_slave_mux.sv
adc_apb_regs.sv
adc_sample_ctrl.sv
tmu_core.sv
tmu_apb_regs.sv
periph_top.sv
tb_periph_top.sv

//--- Bender.yml
package:
  name: periph
sources:
  - periph_pkg.sv
  - apb_slave_mux.sv
  - adc_apb_regs.sv
  - adc_sample_ctrl.sv
  - tmu_core.sv
  - tmu_apb_regs.sv
  - periph_top.sv
  - target: test
    files:
      - tb_periph_top.sv
